// ==== rtl/dma_bus_strobes.sv ====
// ----------------------------------------------------------------------
// Registered bus control pins, one cycle ahead from next_state.
// Each pin therefore matches the state the FSM holds in that cycle.
// Verify transfers drive no read or write strobe.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dma_bus_strobes
    import dma_reg_pkg::*;
    import dma_ctrl_pkg::*;
(
    input  logic            clock,
    input  logic            reset,
    input  logic            master_clear_i,
    input  transfer_state_t state_i,
    input  transfer_state_t next_state_i,
    input  channel_mask_t   active_channel_i,
    input  command_t        command_i,
    input  channel_mode_t   active_mode_i,
    output logic            hold_request_o,
    output logic            address_enable_o,
    output logic            address_strobe_o,
    output channel_mask_t   dack_o,
    output bus_strobe_t     strobes_o
);

    bus_strobe_t   strobes_d;
    channel_mask_t dack_mask;
    logic          read_window;
    logic          write_window;

    always_comb begin
        read_window  = next_state_i inside {S2, S3, SW};
        // Extended write and compressed timing pull the write into S2
        write_window = (next_state_i inside {S3, SW})
                    || (next_state_i == S2
                        && (command_i.extended_write || command_i.compressed_timing));
        strobes_d = STROBES_IDLE;
        case (active_mode_i.transfer_type)
            READ: begin
                strobes_d.memory_read_n = !read_window;
                strobes_d.io_write_n    = !write_window;
            end
            WRITE: begin
                strobes_d.io_read_n      = !read_window;
                strobes_d.memory_write_n = !write_window;
            end
            default: strobes_d = STROBES_IDLE;
        endcase
        dack_mask = (next_state_i inside {S2, S3, SW, S4}) ? active_channel_i : '0;
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset || master_clear_i) begin
            hold_request_o   <= 1'b0;
            address_enable_o <= 1'b0;
            address_strobe_o <= 1'b0;
            dack_o           <= '1;
            strobes_o        <= STROBES_IDLE;
        end else begin
            hold_request_o   <= (next_state_i != SI);
            address_enable_o <= !(next_state_i inside {SI, S0});
            address_strobe_o <= (next_state_i == S1);
            dack_o           <= command_i.dack_active_high ? dack_mask : ~dack_mask;
            strobes_o        <= strobes_d;
        end
    end

    a_no_bus_contention : assert property (
        @(posedge clock) disable iff (reset)
        (strobes_o.memory_read_n || strobes_o.memory_write_n)
        && (strobes_o.io_read_n || strobes_o.io_write_n));

endmodule

`default_nettype wire

// ==== rtl/dma_ctrl_pkg.sv ====
// ----------------------------------------------------------------------
// Transfer states and bus strobe bundle of the DMA controller.
// All bus strobes are active low.
// ----------------------------------------------------------------------
`default_nettype none

package dma_ctrl_pkg;

    // SW is the ready wait state, S4 ends each word
    typedef enum logic [2:0] {
        SI, S0, S1, S2, S3, SW, S4
    } transfer_state_t;

    typedef struct packed {
        logic memory_read_n;
        logic memory_write_n;
        logic io_read_n;
        logic io_write_n;
    } bus_strobe_t;

    localparam bus_strobe_t STROBES_IDLE = '1;

endpackage

`default_nettype wire

// ==== rtl/dma_mode_decode.sv ====
// ----------------------------------------------------------------------
// Command register and the four channel mode registers.
// Master clear resets all of them, as reset does.
// active_channel_i must be one-hot or zero.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dma_mode_decode
    import dma_reg_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  logic          master_clear_i,
    input  data_byte_t    data_i,
    input  logic          write_command_i,
    input  logic          write_mode_i,
    input  channel_mask_t active_channel_i,
    output command_t      command_o,
    output channel_mode_t active_mode_o,
    output channel_mask_t edge_request_o
);

    channel_mode_t  mode_q [NUM_CHANNELS];
    channel_index_t write_index;
    channel_index_t active_index;

    assign write_index = channel_index_t'(data_i[1:0]);

    always_ff @(posedge clock, posedge reset) begin
        if (reset || master_clear_i) begin
            command_o <= '0;
        end else if (write_command_i) begin
            command_o.compressed_timing <= data_i[CMD_COMPRESSED_BIT];
            command_o.extended_write    <= data_i[CMD_EXT_WRITE_BIT];
            command_o.dack_active_high  <= data_i[CMD_DACK_HIGH_BIT];
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset || master_clear_i) begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                mode_q[i] <= '0;
            end
        end else if (write_mode_i) begin
            mode_q[write_index].transfer_type <= transfer_type_t'(data_i[MODE_TYPE_LSB +: 2]);
            mode_q[write_index].autoinit      <= data_i[MODE_AUTOINIT_BIT];
            mode_q[write_index].decrement     <= data_i[MODE_DECREMENT_BIT];
            mode_q[write_index].transfer_mode <= transfer_mode_t'(data_i[MODE_MODE_LSB +: 2]);
        end
    end

    // One-hot grant to channel number
    always_comb begin
        active_index = '0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (active_channel_i[i]) begin
                active_index = channel_index_t'(i);
            end
        end
    end

    assign active_mode_o = mode_q[active_index];

    always_comb begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            edge_request_o[i] = (mode_q[i].transfer_mode == SINGLE)
                             || (mode_q[i].transfer_mode == BLOCK);
        end
    end

    // Grant comes from the FSM capture of the external encoder mask
    a_grant_onehot : assert property (
        @(posedge clock) disable iff (reset) $onehot0(active_channel_i));

endmodule

`default_nettype wire

// ==== rtl/dma_reg_pkg.sv ====
// ----------------------------------------------------------------------
// Register layout of the DMA timing and control block.
// Cascade mode and memory-to-memory are not supported, so a mode byte
// with bits 7:6 set to 3 leaves the channel without a valid mode.
// ----------------------------------------------------------------------
`default_nettype none

package dma_reg_pkg;

    localparam int NUM_CHANNELS = 4;

    typedef logic [7:0]              data_byte_t;
    typedef logic [NUM_CHANNELS-1:0] channel_mask_t;
    typedef logic [1:0]              channel_index_t;

    // Mode byte bits 3:2
    typedef enum logic [1:0] {
        VERIFY = 2'd0, WRITE = 2'd1, READ = 2'd2
    } transfer_type_t;

    // Mode byte bits 7:6
    typedef enum logic [1:0] {
        DEMAND = 2'd0, SINGLE = 2'd1, BLOCK = 2'd2
    } transfer_mode_t;

    typedef struct packed {
        transfer_type_t transfer_type;
        logic           autoinit;
        logic           decrement;
        transfer_mode_t transfer_mode;
    } channel_mode_t;

    typedef struct packed {
        logic compressed_timing;
        logic extended_write;
        logic dack_active_high;
    } command_t;

    localparam int CMD_COMPRESSED_BIT = 3;
    localparam int CMD_EXT_WRITE_BIT  = 5;
    localparam int CMD_DACK_HIGH_BIT  = 7;
    localparam int MODE_TYPE_LSB      = 2;
    localparam int MODE_AUTOINIT_BIT  = 4;
    localparam int MODE_DECREMENT_BIT = 5;
    localparam int MODE_MODE_LSB      = 6;

endpackage

`default_nettype wire

// ==== rtl/dma_timing_control.sv ====
// ----------------------------------------------------------------------
// Timing and control section of a four-channel DMA controller.
// Channel priority is resolved outside, channel_request_i is one-hot.
// Rising clock edge only; no cascade or memory-to-memory support.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dma_timing_control
    import dma_reg_pkg::*;
    import dma_ctrl_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  data_byte_t    data_i,
    input  logic          write_command_i,
    input  logic          write_mode_i,
    input  logic          master_clear_i,
    input  logic          read_status_i,
    input  channel_mask_t channel_request_i,
    input  channel_mask_t dreq_state_i,
    input  logic          hold_acknowledge_i,
    input  logic          ready_i,
    input  logic          eop_n_i,
    input  logic          underflow_i,
    output channel_mask_t edge_request_o,
    output logic          next_word_o,
    output logic          init_current_o,
    output channel_mask_t tc_status_o,
    output logic          eop_n_o,
    output logic          hold_request_o,
    output logic          address_enable_o,
    output logic          address_strobe_o,
    output channel_mask_t dack_o,
    output bus_strobe_t   strobes_o
);

    command_t        command;
    channel_mode_t   active_mode;
    channel_mask_t   active_channel;
    transfer_state_t state;
    transfer_state_t next_state;

    dma_mode_decode u_decode (
        .clock, .reset, .master_clear_i, .data_i, .write_command_i, .write_mode_i,
        .active_channel_i (active_channel),
        .command_o        (command),
        .active_mode_o    (active_mode),
        .edge_request_o
    );

    dma_transfer_fsm u_fsm (
        .clock, .reset, .master_clear_i, .channel_request_i, .dreq_state_i,
        .hold_acknowledge_i, .ready_i, .eop_n_i, .underflow_i, .read_status_i,
        .command_i        (command),
        .active_mode_i    (active_mode),
        .state_o          (state),
        .next_state_o     (next_state),
        .active_channel_o (active_channel),
        .next_word_o, .eop_n_o, .init_current_o, .tc_status_o
    );

    dma_bus_strobes u_strobes (
        .clock, .reset, .master_clear_i,
        .state_i          (state),
        .next_state_i     (next_state),
        .active_channel_i (active_channel),
        .command_i        (command),
        .active_mode_i    (active_mode),
        .hold_request_o, .address_enable_o, .address_strobe_o, .dack_o, .strobes_o
    );

endmodule

`default_nettype wire

// ==== rtl/dma_transfer_fsm.sv ====
// ----------------------------------------------------------------------
// Transfer state machine with end-of-process and terminal count status.
// The granted channel is taken from channel_request_i while idle.
// Status bits clear on the cycle after read_status_i falls.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dma_transfer_fsm
    import dma_reg_pkg::*;
    import dma_ctrl_pkg::*;
(
    input  logic            clock,
    input  logic            reset,
    input  logic            master_clear_i,
    input  channel_mask_t   channel_request_i,
    input  channel_mask_t   dreq_state_i,
    input  logic            hold_acknowledge_i,
    input  logic            ready_i,
    input  logic            eop_n_i,
    input  logic            underflow_i,
    input  logic            read_status_i,
    input  command_t        command_i,
    input  channel_mode_t   active_mode_i,
    output transfer_state_t state_o,
    output transfer_state_t next_state_o,
    output channel_mask_t   active_channel_o,
    output logic            next_word_o,
    output logic            eop_n_o,
    output logic            init_current_o,
    output channel_mask_t   tc_status_o
);

    transfer_state_t state_q;
    transfer_state_t next_state;
    logic            terminal_count;
    logic            external_eop;
    logic            end_of_process;
    logic            read_status_q;
    logic            is_verify;

    assign is_verify = (active_mode_i.transfer_type == VERIFY);

    always_comb begin
        next_state = state_q;
        unique case (state_q)
            SI: if (channel_request_i != '0) next_state = S0;
            S0: if (hold_acknowledge_i) next_state = S1;
            S1: next_state = S2;
            S2: begin
                if (!command_i.compressed_timing) begin
                    next_state = S3;
                end else if (!is_verify) begin
                    next_state = SW;
                end else if (ready_i) begin
                    next_state = S4;
                end
            end
            S3: begin
                if (!is_verify) begin
                    next_state = SW;
                end else if (ready_i) begin
                    next_state = S4;
                end
            end
            SW: if (ready_i) next_state = S4;
            S4: begin
                if (active_mode_i.transfer_mode == SINGLE || end_of_process) begin
                    next_state = SI;
                end else if (active_mode_i.transfer_mode == DEMAND
                             && (active_channel_o & dreq_state_i) == '0) begin
                    next_state = SI;
                end else begin
                    next_state = S2;
                end
            end
            default: next_state = SI;
        endcase
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset || master_clear_i) begin
            state_q          <= SI;
            active_channel_o <= '0;
            terminal_count   <= 1'b0;
            external_eop     <= 1'b0;
        end else begin
            state_q <= next_state;
            if (state_q == SI) begin
                active_channel_o <= channel_request_i;
            end
            // Underflow is sampled as the word completes
            if (next_word_o) begin
                terminal_count <= underflow_i;
            end else if (state_q == S4) begin
                terminal_count <= 1'b0;
            end
            if (state_q == SI) begin
                external_eop <= 1'b0;
            end else if (next_state == S2 && !eop_n_i) begin
                external_eop <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            read_status_q <= 1'b0;
            tc_status_o   <= '0;
        end else begin
            read_status_q <= read_status_i;
            if (master_clear_i || (read_status_q && !read_status_i)) begin
                tc_status_o <= '0;
            end else if (state_q == S4 && terminal_count) begin
                tc_status_o <= tc_status_o | active_channel_o;
            end
        end
    end

    assign end_of_process = (state_q == S4) && (terminal_count || external_eop);
    assign next_word_o    = (next_state == S4);
    assign eop_n_o        = !terminal_count;
    assign init_current_o = end_of_process && active_mode_i.autoinit;
    assign state_o        = state_q;
    assign next_state_o   = next_state;

    // The bus is never driven before the CPU hands it over
    a_hold_before_s1 : assert property (
        @(posedge clock) disable iff (reset)
        (state_q == S0 && !hold_acknowledge_i && !master_clear_i) |=> state_q == S0);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the DMA timing and control testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f \
    --top-module tb_dma_timing_control -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "TEST PASS"; then
    exit 0
fi
exit 1

// ==== sources.f ====
rtl/dma_reg_pkg.sv
rtl/dma_ctrl_pkg.sv
rtl/dma_mode_decode.sv
rtl/dma_transfer_fsm.sv
rtl/dma_bus_strobes.sv
rtl/dma_timing_control.sv
tests/tb_dma_timing_control.sv

// ==== tests/tb_dma_timing_control.sv ====
// ----------------------------------------------------------------------
// Directed testbench for the DMA timing and control block.
// Inputs change and outputs are sampled on the falling clock edge.
// Hold acknowledge comes from a responder half a cycle after request.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_dma_timing_control
    import dma_reg_pkg::*;
    import dma_ctrl_pkg::*;
();

    localparam int CLOCK_PERIOD    = 4;
    localparam int TEST_CYCLES     = 100;
    localparam int TIMEOUT_NS      = 10 * TEST_CYCLES * CLOCK_PERIOD;
    localparam int WAIT_LIMIT      = 20;
    localparam int LOOP_LIMIT      = 80;
    localparam int SEL_HOLD        = 0;
    localparam int SEL_ADDR_STROBE = 1;

    logic          clock;
    logic          reset;
    data_byte_t    data_i;
    logic          write_command_i;
    logic          write_mode_i;
    logic          master_clear_i;
    logic          read_status_i;
    channel_mask_t channel_request_i;
    channel_mask_t dreq_state_i;
    logic          hold_acknowledge_i;
    logic          ready_i;
    logic          eop_n_i;
    logic          underflow_i;
    channel_mask_t edge_request_o;
    logic          next_word_o;
    logic          init_current_o;
    channel_mask_t tc_status_o;
    logic          eop_n_o;
    logic          hold_request_o;
    logic          address_enable_o;
    logic          address_strobe_o;
    channel_mask_t dack_o;
    bus_strobe_t   strobes_o;
    int            errors;
    int            seed;

    dma_timing_control dut0 (.*);

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // CPU side hands over the bus
    initial begin
        hold_acknowledge_i = 1'b0;
        forever begin
            @(negedge clock);
            hold_acknowledge_i <= hold_request_o;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, the tests did not finish", TIMEOUT_NS);
        $display("TEST FAIL");
        $finish;
    end

    function automatic bus_strobe_t strobe_levels(input logic mr, input logic mw,
                                                  input logic ior, input logic iow);
        bus_strobe_t s;
        s.memory_read_n  = mr;
        s.memory_write_n = mw;
        s.io_read_n      = ior;
        s.io_write_n     = iow;
        return s;
    endfunction

    function automatic logic sample_signal(input int sel);
        case (sel)
            SEL_HOLD:        return hold_request_o;
            SEL_ADDR_STROBE: return address_strobe_o;
            default:         return 1'b0;
        endcase
    endfunction

    task automatic check_strobes(input string name, input bus_strobe_t actual,
                                 input bus_strobe_t expected);
        if (actual !== expected) begin
            $display("Fail at %0t: %s is %b, expected %b", $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic check_mask(input string name, input channel_mask_t actual,
                              input channel_mask_t expected);
        if (actual !== expected) begin
            $display("Fail at %0t: %s is %b, expected %b", $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("Fail at %0t: %s is %b, expected %b", $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("Fail at %0t: %s counted %0d, expected %0d", $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic check_ended(input string what);
        if (hold_request_o) begin
            $display("At %0t: the %s transfer never released the bus", $time, what);
            errors++;
        end
    endtask

    task automatic write_command(input data_byte_t value);
        data_i          = value;
        write_command_i = 1'b1;
        @(negedge clock);
        write_command_i = 1'b0;
    endtask

    task automatic write_mode(input data_byte_t value);
        data_i       = value;
        write_mode_i = 1'b1;
        @(negedge clock);
        write_mode_i = 1'b0;
    endtask

    task automatic wait_for_level(input int sel, input string what);
        int n;
        n = 0;
        @(negedge clock);
        while (!sample_signal(sel) && n < WAIT_LIMIT) begin
            @(negedge clock);
            n++;
        end
        if (!sample_signal(sel)) begin
            $display("At %0t: %s never went high", $time, what);
            errors++;
        end
    endtask

    // Returns at the falling edge inside S1
    task automatic start_transfer(input channel_mask_t channel);
        channel_request_i = channel;
        wait_for_level(SEL_HOLD, "hold_request_o");
        channel_request_i = '0;
        wait_for_level(SEL_ADDR_STROBE, "address_strobe_o");
        check_bit("address_enable_o", address_enable_o, 1'b1);
    endtask

    task automatic after_reset_check();
        @(negedge clock);
        check_strobes("strobes_o", strobes_o, STROBES_IDLE);
        check_mask("dack_o", dack_o, 4'b1111);
        check_bit("hold_request_o", hold_request_o, 1'b0);
        check_bit("address_enable_o", address_enable_o, 1'b0);
        check_bit("address_strobe_o", address_strobe_o, 1'b0);
        check_bit("next_word_o", next_word_o, 1'b0);
        check_mask("tc_status_o", tc_status_o, 4'b0000);
    endtask

    task automatic single_read_channel2();
        write_command(8'h00);
        write_mode(8'h4A);
        ready_i = 1'b1;
        start_transfer(4'b0100);
        @(negedge clock);
        check_bit("address_strobe_o", address_strobe_o, 1'b0);
        check_mask("dack_o", dack_o, 4'b1011);
        check_strobes("strobes_o", strobes_o, strobe_levels(1'b0, 1'b1, 1'b1, 1'b1));
        @(negedge clock);
        check_strobes("strobes_o", strobes_o, strobe_levels(1'b0, 1'b1, 1'b1, 1'b0));
        check_bit("next_word_o", next_word_o, 1'b0);
        @(negedge clock);
        check_strobes("strobes_o", strobes_o, strobe_levels(1'b0, 1'b1, 1'b1, 1'b0));
        check_bit("next_word_o", next_word_o, 1'b1);
        @(negedge clock);
        check_strobes("strobes_o", strobes_o, STROBES_IDLE);
        check_bit("next_word_o", next_word_o, 1'b0);
        @(negedge clock);
        check_bit("hold_request_o", hold_request_o, 1'b0);
        check_mask("dack_o", dack_o, 4'b1111);
    endtask

    task automatic compressed_write_channel3();
        int waits;
        waits = 1 + int'($unsigned($random(seed)) % 4);
        write_command(8'h88);
        write_mode(8'h47);
        ready_i = 1'b0;
        start_transfer(4'b1000);
        @(negedge clock);
        check_mask("dack_o", dack_o, 4'b1000);
        check_strobes("strobes_o", strobes_o, strobe_levels(1'b1, 1'b0, 1'b0, 1'b1));
        // Ready low keeps the FSM in SW
        for (int i = 0; i < waits; i++) begin
            @(negedge clock);
            check_strobes("strobes_o", strobes_o, strobe_levels(1'b1, 1'b0, 1'b0, 1'b1));
            check_bit("next_word_o", next_word_o, 1'b0);
        end
        ready_i = 1'b1;
        @(negedge clock);
        check_strobes("strobes_o", strobes_o, STROBES_IDLE);
        @(negedge clock);
        check_bit("hold_request_o", hold_request_o, 1'b0);
        check_mask("dack_o", dack_o, 4'b0000);
    endtask

    task automatic block_read_with_tc();
        int n;
        int words;
        int eops;
        int inits;
        int cycles;
        n      = 2 + int'($unsigned($random(seed)) % 3);
        words  = 0;
        eops   = 0;
        inits  = 0;
        cycles = 0;
        write_command(8'h00);
        write_mode(8'h99);
        check_mask("edge_request_o", edge_request_o, 4'b1110);
        ready_i = 1'b1;
        start_transfer(4'b0010);
        while (hold_request_o && cycles < LOOP_LIMIT) begin
            @(negedge clock);
            cycles++;
            if (next_word_o) begin
                words++;
            end
            if (!eop_n_o) begin
                eops++;
            end
            if (init_current_o) begin
                inits++;
            end
            // Counter runs out on the last word
            if (words == n - 1 && !next_word_o) begin
                underflow_i = 1'b1;
            end
        end
        underflow_i = 1'b0;
        check_ended("block");
        check_count("next_word_o pulses", words, n);
        check_count("eop_n_o low cycles", eops, 1);
        check_count("init_current_o pulses", inits, 1);
        check_mask("tc_status_o", tc_status_o, 4'b0010);
        read_status_i = 1'b1;
        @(negedge clock);
        check_mask("tc_status_o", tc_status_o, 4'b0010);
        read_status_i = 1'b0;
        @(negedge clock);
        check_mask("tc_status_o", tc_status_o, 4'b0000);
    endtask

    task automatic demand_verify_channel0();
        int words;
        int cycles;
        words  = 0;
        cycles = 0;
        write_mode(8'h00);
        dreq_state_i = 4'b0001;
        start_transfer(4'b0001);
        while (hold_request_o && cycles < LOOP_LIMIT) begin
            @(negedge clock);
            cycles++;
            check_strobes("strobes_o", strobes_o, STROBES_IDLE);
            if (next_word_o) begin
                words++;
                if (words == 2) begin
                    dreq_state_i = 4'b0000;
                end
            end
        end
        check_ended("demand verify");
        check_count("next_word_o pulses", words, 2);
    endtask

    task automatic demand_read_eop_channel0();
        int words;
        int cycles;
        words  = 0;
        cycles = 0;
        write_mode(8'h08);
        dreq_state_i = 4'b0001;
        start_transfer(4'b0001);
        while (hold_request_o && cycles < LOOP_LIMIT) begin
            @(negedge clock);
            cycles++;
            check_bit("eop_n_o", eop_n_o, 1'b1);
            if (next_word_o) begin
                words++;
                if (words == 2) begin
                    eop_n_i = 1'b0;
                end
            end
        end
        eop_n_i      = 1'b1;
        dreq_state_i = 4'b0000;
        check_ended("demand read");
        // EOP during word 2 is seen on entry to the third S2
        check_count("next_word_o pulses", words, 3);
        check_mask("tc_status_o", tc_status_o, 4'b0000);
    endtask

    initial begin
        errors            = 0;
        seed              = 30;
        reset             = 1'b1;
        data_i            = '0;
        write_command_i   = 1'b0;
        write_mode_i      = 1'b0;
        master_clear_i    = 1'b0;
        read_status_i     = 1'b0;
        channel_request_i = '0;
        dreq_state_i      = '0;
        ready_i           = 1'b1;
        eop_n_i           = 1'b1;
        underflow_i       = 1'b0;
        repeat (3) @(negedge clock);
        reset = 1'b0;
        after_reset_check();
        single_read_channel2();
        compressed_write_channel3();
        block_read_with_tc();
        demand_verify_channel0();
        demand_read_eop_channel0();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
